//--- dv/int_div_tb.sv
// testbench for the iterative divider
// directed table plus seeded random entries, reference model, back-pressure
`default_nettype none

module int_div_tb;

  // ------------------------------
  // sizing and limits
  // ------------------------------

  localparam int num_directed = 16;
  localparam int num_random   = 48;
  localparam int num_entries  = num_directed + num_random;
  // accept to first resp_val
  localparam int latency      = int_div_pkg::num_steps + 2;
  // latency, longest stall and handshake overhead per entry, plus reset
  localparam int timeout_cycles = num_entries * (latency + 5 + 4) + 100;

  localparam logic fn_u = int_div_pkg::div_fn_unsigned;
  localparam logic fn_s = int_div_pkg::div_fn_signed;

  // fn, a, b, expected rem, expected quo
  localparam logic [128:0] dir_table [num_directed] = '{
    {fn_u, 32'h0000_0064, 32'h0000_0007, 32'h0000_0002, 32'h0000_000e},
    {fn_u, 32'hffff_fff0, 32'h0000_0000, 32'hffff_fff0, 32'hffff_ffff},
    {fn_u, 32'h0000_0005, 32'h0000_0009, 32'h0000_0005, 32'h0000_0000},
    {fn_u, 32'hffff_ffff, 32'h0001_0000, 32'h0000_ffff, 32'h0000_ffff},
    {fn_s, 32'h0000_0064, 32'h0000_0007, 32'h0000_0002, 32'h0000_000e},
    {fn_s, 32'hffff_ff9c, 32'h0000_0007, 32'hffff_fffe, 32'hffff_fff2},
    {fn_s, 32'h0000_0064, 32'hffff_fff9, 32'h0000_0002, 32'hffff_fff2},
    {fn_s, 32'hffff_ff9c, 32'hffff_fff9, 32'hffff_fffe, 32'h0000_000e},
    {fn_s, 32'h0000_002a, 32'hffff_fffa, 32'h0000_0000, 32'hffff_fff9},
    {fn_s, 32'hffff_fffd, 32'h0000_0008, 32'hffff_fffd, 32'h0000_0000},
    {fn_u, 32'h0000_04d2, 32'h0000_0000, 32'h0000_04d2, 32'hffff_ffff},
    {fn_s, 32'hffff_fffb, 32'h0000_0000, 32'hffff_fffb, 32'hffff_ffff},
    {fn_s, 32'h0000_004d, 32'h0000_0000, 32'h0000_004d, 32'hffff_ffff},
    {fn_s, 32'h8000_0000, 32'hffff_ffff, 32'h0000_0000, 32'h8000_0000},
    {fn_u, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000, 32'h0000_0000},
    {fn_s, 32'h8000_0000, 32'h0000_0002, 32'h0000_0000, 32'hc000_0000}
  };

  // ------------------------------
  // DUT and clock
  // ------------------------------

  logic                   clk = 1'b0;
  logic                   reset;
  int_div_pkg::div_req_t  req;
  logic                   req_val;
  logic                   req_rdy;
  int_div_pkg::div_resp_t resp;
  logic                   resp_val;
  logic                   resp_rdy;

  int errors     = 0;
  int checks     = 0;
  int resp_count = 0;
  int cycles     = 0;

  int_div_iterative u_int_div_iterative (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  always #20 clk = ~clk;

  // responses taken, counted half a cycle before the transfer edge
  always @(negedge clk) begin
    if (resp_val && resp_rdy) begin
      resp_count = resp_count + 1;
    end
  end

  // run limit
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("timeout, the divider did not finish within %0d cycles", timeout_cycles);
      $display("checks %0d, errors %0d", checks, errors + 1);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // ------------------------------
  // checking and reference
  // ------------------------------

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks = checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // truncating division on magnitudes, quotient sign from both operands
  function automatic int_div_pkg::div_resp_t ref_div(input int_div_pkg::div_req_t r);
    logic                   is_s;
    logic                   sa;
    logic                   sb;
    logic [31:0]            ma;
    logic [31:0]            mb;
    logic [31:0]            q;
    logic [31:0]            rm;
    int_div_pkg::div_resp_t res;
    is_s = (r.fn == int_div_pkg::div_fn_signed);
    sa   = is_s && r.a[31];
    sb   = is_s && r.b[31];
    if (r.b == 32'd0) begin
      res.quo = 32'hffff_ffff;
      res.rem = r.a;
    end else if (is_s && r.a == 32'h8000_0000 && r.b == 32'hffff_ffff) begin
      // signed overflow
      res.quo = 32'h8000_0000;
      res.rem = 32'd0;
    end else begin
      ma      = sa ? (32'd0 - r.a) : r.a;
      mb      = sb ? (32'd0 - r.b) : r.b;
      q       = ma / mb;
      rm      = ma % mb;
      res.quo = (sa ^ sb) ? (32'd0 - q) : q;
      res.rem = sa ? (32'd0 - rm) : rm;
    end
    return res;
  endfunction

  // ------------------------------
  // one request through the DUT
  // ------------------------------

  task automatic apply_entry(input int_div_pkg::div_req_t r,
                             input int_div_pkg::div_resp_t exp, input int hold);
    int lat;
    int i;
    int seen_before;
    seen_before = resp_count;
    @(posedge clk);
    req     <= r;
    req_val <= 1'b1;
    @(negedge clk);
    while (!req_rdy) begin
      @(negedge clk);
    end
    // accepting edge
    @(posedge clk);
    req_val <= 1'b0;
    req     <= '0;
    lat = 0;
    @(negedge clk);
    // busy, count edges until the response shows
    while (!resp_val) begin
      check("req_rdy", 64'(req_rdy), 64'(0));
      @(negedge clk);
      lat = lat + 1;
    end
    check("latency", 64'(lat), 64'(latency));
    check("resp.quo", 64'(resp.quo), 64'(exp.quo));
    check("resp.rem", 64'(resp.rem), 64'(exp.rem));
    // stall the consumer
    for (i = 0; i < hold; i = i + 1) begin
      @(negedge clk);
      check("resp_val", 64'(resp_val), 64'(1));
      check("resp", 64'(resp), 64'(exp));
      check("req_rdy", 64'(req_rdy), 64'(0));
    end
    @(posedge clk);
    resp_rdy <= 1'b1;
    // transfer edge
    @(posedge clk);
    resp_rdy <= 1'b0;
    @(negedge clk);
    check("resp_val", 64'(resp_val), 64'(0));
    check("resp_count", 64'(resp_count - seen_before), 64'(1));
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------

  initial begin
    int_div_pkg::div_req_t  r;
    int_div_pkg::div_resp_t exp;
    logic [128:0]           row;
    logic [31:0]            rnd;
    int                     hold;
    int                     n;
    void'($urandom(32'h4034));
    reset    <= 1'b1;
    req      <= '0;
    req_val  <= 1'b0;
    resp_rdy <= 1'b0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check("req_rdy", 64'(req_rdy), 64'(1));
    check("resp_val", 64'(resp_val), 64'(0));

    // directed entries, no stall
    for (n = 0; n < num_directed; n = n + 1) begin
      row = dir_table[n];
      r   = row[128:64];
      exp = row[63:0];
      apply_entry(r, exp, 0);
    end

    // random entries, divisor shifted down to reach small values and zero
    for (n = 0; n < num_random; n = n + 1) begin
      rnd  = $urandom;
      r.fn = int_div_pkg::div_fn_e'(rnd[0]);
      r.a  = $urandom;
      r.b  = $urandom >> rnd[5:1];
      hold = $urandom_range(5, 0);
      exp  = ref_div(r);
      apply_entry(r, exp, hold);
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
verilog/int_div_pkg.sv
verilog/int_div_ctrl.sv
verilog/int_div_step_counter.sv
verilog/int_div_operand_prep.sv
verilog/int_div_shift_sub.sv
verilog/int_div_result_fixup.sv
verilog/int_div_iterative.sv
dv/int_div_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the divider testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module int_div_tb -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator compile failed with status $status"
  exit 1
fi

out=$(./obj_dir/Vint_div_tb)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
  exit 0
else
  echo "pass message not found"
  exit 1
fi

//--- verilog/int_div_ctrl.sv
// control FSM for the iterative divider
// sequences accept, load, iterate, fixup and respond
`default_nettype none

module int_div_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  input  logic resp_rdy,
  input  logic last_step,
  output logic req_rdy,
  output logic resp_val,
  output logic prep_en,
  output logic load_en,
  output logic step_en,
  output logic cnt_clear,
  output logic cnt_en,
  output logic fix_en
);

  // ------------------------------
  // state register
  // ------------------------------

  typedef enum logic [2:0] {
    st_idle,
    st_load,
    st_calc,
    st_fixup,
    st_done
  } state_e;

  state_e state;
  state_e state_next;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  // ------------------------------
  // next state
  // ------------------------------

  always_comb begin
    state_next = state;
    case (state)
      // wait for a request transfer
      st_idle:  if (prep_en) state_next = st_load;
      // shift_sub takes the magnitudes this cycle
      st_load:  state_next = st_calc;
      // 32 steps, leave after the last one
      st_calc:  if (last_step) state_next = st_fixup;
      st_fixup: state_next = st_done;
      // hold the response until the consumer takes it
      st_done:  if (resp_rdy) state_next = st_idle;
      default:  state_next = st_idle;
    endcase
  end

  // ------------------------------
  // outputs, decoded from state
  // ------------------------------

  assign req_rdy   = (state == st_idle);
  // request captured on the accepting edge
  assign prep_en   = req_rdy && req_val;
  assign load_en   = (state == st_load);
  assign cnt_clear = (state == st_load);
  assign step_en   = (state == st_calc);
  assign cnt_en    = (state == st_calc);
  assign fix_en    = (state == st_fixup);
  assign resp_val  = (state == st_done);

  // the counter only flags the last step while iterating
  last_step_in_calc: assert property (@(posedge clk) disable iff (reset)
    last_step |-> step_en);

endmodule

`default_nettype wire

//--- verilog/int_div_iterative.sv
// top level of the iterative 32-bit divider
// control, step counter and datapath on val/rdy ports
`default_nettype none

module int_div_iterative (
  input  logic                   clk,
  input  logic                   reset,
  input  int_div_pkg::div_req_t  req,
  input  logic                   req_val,
  output logic                   req_rdy,
  output int_div_pkg::div_resp_t resp,
  output logic                   resp_val,
  input  logic                   resp_rdy
);

  // ------------------------------
  // internal nets
  // ------------------------------

  // control strobes
  logic prep_en;
  logic load_en;
  logic step_en;
  logic cnt_clear;
  logic cnt_en;
  logic fix_en;
  logic last_step;

  // datapath between the blocks
  logic [31:0] mag_a;
  logic [31:0] mag_b;
  logic        neg_quo;
  logic        neg_rem;
  logic [31:0] quo_mag;
  logic [31:0] rem_mag;

  // ------------------------------
  // control
  // ------------------------------

  int_div_ctrl u_ctrl (
    .clk       (clk),
    .reset     (reset),
    .req_val   (req_val),
    .resp_rdy  (resp_rdy),
    .last_step (last_step),
    .req_rdy   (req_rdy),
    .resp_val  (resp_val),
    .prep_en   (prep_en),
    .load_en   (load_en),
    .step_en   (step_en),
    .cnt_clear (cnt_clear),
    .cnt_en    (cnt_en),
    .fix_en    (fix_en)
  );

  int_div_step_counter u_step_counter (
    .clk       (clk),
    .reset     (reset),
    .clear     (cnt_clear),
    .en        (cnt_en),
    .last_step (last_step)
  );

  // ------------------------------
  // datapath
  // ------------------------------

  int_div_operand_prep u_operand_prep (
    .clk     (clk),
    .reset   (reset),
    .req     (req),
    .en      (prep_en),
    .mag_a   (mag_a),
    .mag_b   (mag_b),
    .neg_quo (neg_quo),
    .neg_rem (neg_rem)
  );

  int_div_shift_sub u_shift_sub (
    .clk     (clk),
    .reset   (reset),
    .load    (load_en),
    .step    (step_en),
    .mag_a   (mag_a),
    .mag_b   (mag_b),
    .quo_mag (quo_mag),
    .rem_mag (rem_mag)
  );

  int_div_result_fixup u_result_fixup (
    .clk     (clk),
    .reset   (reset),
    .en      (fix_en),
    .quo_mag (quo_mag),
    .rem_mag (rem_mag),
    .neg_quo (neg_quo),
    .neg_rem (neg_rem),
    .resp    (resp)
  );

endmodule

`default_nettype wire

//--- verilog/int_div_operand_prep.sv
// operand capture and magnitude conversion
// sign flags for the final fixup, zero-divisor detect
`default_nettype none

module int_div_operand_prep (
  input  logic                  clk,
  input  logic                  reset,
  input  int_div_pkg::div_req_t req,
  input  logic                  en,
  output logic [31:0]           mag_a,
  output logic [31:0]           mag_b,
  output logic                  neg_quo,
  output logic                  neg_rem
);

  // ------------------------------
  // request register
  // ------------------------------

  int_div_pkg::div_req_t req_r;

  // function bit comes up unsigned after reset
  always_ff @(posedge clk) begin
    if (reset) begin
      req_r.fn <= int_div_pkg::div_fn_unsigned;
    end else if (en) begin
      req_r.fn <= req.fn;
    end
  end

  // operands
  always_ff @(posedge clk) begin
    if (en) begin
      req_r.a <= req.a;
      req_r.b <= req.b;
    end
  end

  // ------------------------------
  // magnitudes and flags
  // ------------------------------

  logic is_signed;
  logic neg_a;
  logic neg_b;
  logic b_zero;

  assign is_signed = (req_r.fn == int_div_pkg::div_fn_signed);
  // sign bits only count for the signed function
  assign neg_a     = is_signed && req_r.a[31];
  assign neg_b     = is_signed && req_r.b[31];
  assign b_zero    = (req_r.b == 32'd0);

  // two's complement magnitude, most negative value maps to itself
  assign mag_a = neg_a ? (~req_r.a + 32'd1) : req_r.a;
  assign mag_b = neg_b ? (~req_r.b + 32'd1) : req_r.b;

  // all-ones quotient on divide by zero must not be negated
  assign neg_quo = (neg_a ^ neg_b) && !b_zero;
  // remainder follows the dividend
  assign neg_rem = neg_a;

endmodule

`default_nettype wire

//--- verilog/int_div_pkg.sv
// shared types for the iterative integer divider
// request, response and function encodings, step-count constants
`default_nettype none

package int_div_pkg;

  // ------------------------------
  // function select
  // ------------------------------

  // operand interpretation for one division
  typedef enum logic [0:0] {
    div_fn_unsigned = 1'b0,
    div_fn_signed   = 1'b1
  } div_fn_e;

  // ------------------------------
  // request and response words
  // ------------------------------

  // 65-bit request, function bit on top
  typedef struct packed {
    div_fn_e     fn;
    logic [31:0] a;
    logic [31:0] b;
  } div_req_t;

  // 64-bit response, remainder in the upper half
  typedef struct packed {
    logic [31:0] rem;
    logic [31:0] quo;
  } div_resp_t;

  // ------------------------------
  // iteration constants
  // ------------------------------

  // width of the step counter
  localparam int step_count_w = 6;

  // one shift-subtract step per quotient bit
  localparam int num_steps = 32;

endpackage

`default_nettype wire

//--- verilog/int_div_result_fixup.sv
// sign correction of quotient and remainder
// response holding register
`default_nettype none

module int_div_result_fixup (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   en,
  input  logic [31:0]            quo_mag,
  input  logic [31:0]            rem_mag,
  input  logic                   neg_quo,
  input  logic                   neg_rem,
  output int_div_pkg::div_resp_t resp
);

  // ------------------------------
  // sign correction
  // ------------------------------

  int_div_pkg::div_resp_t resp_next;

  // negate each half on its own flag
  assign resp_next.quo = neg_quo ? (~quo_mag + 32'd1) : quo_mag;
  assign resp_next.rem = neg_rem ? (~rem_mag + 32'd1) : rem_mag;

  // ------------------------------
  // response register
  // ------------------------------

  // written once per division, held through back-pressure
  always_ff @(posedge clk) begin
    if (reset) begin
      resp <= '0;
    end else if (en) begin
      resp <= resp_next;
    end
  end

endmodule

`default_nettype wire

//--- verilog/int_div_shift_sub.sv
// restoring shift-subtract datapath
// 64-bit remainder/quotient register and divisor register
`default_nettype none

module int_div_shift_sub (
  input  logic        clk,
  input  logic        reset,
  input  logic        load,
  input  logic        step,
  input  logic [31:0] mag_a,
  input  logic [31:0] mag_b,
  output logic [31:0] quo_mag,
  output logic [31:0] rem_mag
);

  // ------------------------------
  // registers
  // ------------------------------

  // upper half partial remainder, lower half dividend bits
  // being shifted out and quotient bits shifted in
  logic [63:0] pr;
  logic [31:0] divisor;

  // ------------------------------
  // trial subtract
  // ------------------------------

  // upper half after the shift, including the bit shifted out
  logic [32:0] trial_hi;
  logic [32:0] diff;
  logic        fits;
  logic [63:0] pr_next;

  assign trial_hi = pr[63:31];
  assign diff     = trial_hi - {1'b0, divisor};
  // no borrow means the divisor fits
  assign fits     = !diff[32];

  always_comb begin
    if (fits) begin
      // keep difference, quotient bit one
      pr_next = {diff[31:0], pr[30:0], 1'b1};
    end else begin
      // restore, quotient bit zero
      pr_next = {pr[62:0], 1'b0};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pr <= '0;
    end else if (load) begin
      pr <= {32'd0, mag_a};
    end else if (step) begin
      pr <= pr_next;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      divisor <= mag_b;
    end
  end

  // valid after the 32nd step
  assign rem_mag = pr[63:32];
  assign quo_mag = pr[31:0];

  // ctrl never loads in the middle of a division
  load_step_excl: assert property (@(posedge clk) disable iff (reset)
    !(load && step));

endmodule

`default_nettype wire

//--- verilog/int_div_step_counter.sv
// step counter for the shift-subtract iterations
// flags the last of the num_steps steps
`default_nettype none

module int_div_step_counter (
  input  logic clk,
  input  logic reset,
  input  logic clear,
  input  logic en,
  output logic last_step
);

  logic [int_div_pkg::step_count_w-1:0] count;

  // clear wins over increment
  always_ff @(posedge clk) begin
    if (reset || clear) begin
      count <= '0;
    end else if (en) begin
      count <= count + 1'b1;
    end
  end

  // high during the 32nd step cycle
  assign last_step =
    (count == int_div_pkg::step_count_w'(int_div_pkg::num_steps - 1));

  // ctrl must stop stepping once last_step has been seen
  count_in_range: assert property (@(posedge clk) disable iff (reset)
    en |-> (count <= int_div_pkg::step_count_w'(int_div_pkg::num_steps - 1)));

endmodule

`default_nettype wire
